// File: ice51.f
logic/ice51_pkg.sv
logic/uart_rx_loader.sv
logic/uart_tx.sv
logic/cpu_sequencer.sv
logic/cpu_datapath.sv
logic/ice51_top.sv
verif/tb_ice51.sv

// File: logic/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  ice51_pkg::exec_t i_exec,
   input  logic             i_tx_busy,
   output logic             o_acc_zero,
   output logic             o_tx_start,
   output logic [7:0]       o_tx_byte
);
   import ice51_pkg::*;

   opcode_e     op;
   logic [7:0]  imm;
   logic [7:0]  acc;
   logic [7:0]  acc_next;
   logic [15:0] dptr;
   logic        at_tx_data;
   logic        at_tx_stat;

   assign op  = i_exec.instr.op;
   assign imm = i_exec.instr.h_data;

   assign at_tx_data = (dptr == TX_DATA_ADDR);
   assign at_tx_stat = (dptr == TX_STAT_ADDR);

   //////////////////////////////////////////////////
   // accumulator alu

   always_comb begin
      acc_next = acc;
      case (op)
         OP_INCA:   acc_next = acc + 8'd1;
         OP_DECA:   acc_next = acc - 8'd1;
         OP_ADDAI:  acc_next = acc + imm;   // no carry kept
         OP_ORLAI:  acc_next = acc | imm;
         OP_ANLAI:  acc_next = acc & imm;
         OP_XRLAI:  acc_next = acc ^ imm;
         OP_MOVAI:  acc_next = imm;
         OP_CLRA:   acc_next = 8'd0;
         OP_CPLA:   acc_next = ~acc;
         OP_MOVXAD: begin
            if (at_tx_stat) acc_next = {7'd0, i_tx_busy};   // busy poll
         end
         default:   acc_next = acc;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         acc <= 8'd0;
      else if (i_exec.ex)
         acc <= acc_next;
   end

   //////////////////////////////////////////////////
   // dptr and uart store

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         dptr <= 16'd0;
      else if (i_exec.ex && op == OP_MOVDP)
         dptr <= {i_exec.instr.h_data, i_exec.instr.l_data};   // high byte first
   end

   assign o_acc_zero = (acc == 8'd0);
   assign o_tx_start = i_exec.ex && (op == OP_MOVXDA) && at_tx_data;
   assign o_tx_byte  = acc;

   // a store only comes from execute, and the transmitter is busy right after
   a_tx_start_exec: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_tx_start |-> i_exec.ex ##1 i_tx_busy);

endmodule

// File: logic/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  logic                          i_load_done,
   input  logic [7:0]                    i_code_data,
   input  logic                          i_acc_zero,
   output logic [ice51_pkg::CODE_AW-1:0] o_pc,
   output ice51_pkg::exec_t              o_exec
);
   import ice51_pkg::*;

   cpu_state_e         state;
   cpu_state_e         state_next;
   logic               run;        // loading finished, last write out of the way
   opcode_e            op_q;
   opcode_e            op_now;
   logic [7:0]         h_q;
   logic [7:0]         l_q;
   logic [1:0]         len_now;    // operand bytes still to fetch
   logic [CODE_AW-1:0] pc;
   logic [CODE_AW-1:0] pc_next;
   logic [CODE_AW-1:0] pc_rel;
   logic [CODE_AW-1:0] pc_abs;
   logic               take;

   function automatic logic [1:0] operand_bytes(input opcode_e op);
      case (op)
         OP_LJMP, OP_MOVDP: operand_bytes = 2'd2;
         OP_ADDAI, OP_ORLAI, OP_ANLAI, OP_XRLAI, OP_MOVAI,
         OP_JZ, OP_JNZ, OP_SJMP: operand_bytes = 2'd1;
         default: operand_bytes = 2'd0;   // unknown opcodes act as one-byte nop
      endcase
   endfunction

   //////////////////////////////////////////////////
   // state machine

   assign op_now  = (state == ST_DECODE0) ? opcode_e'(i_code_data) : op_q;
   assign len_now = operand_bytes(op_now);

   always_comb begin
      state_next = state;
      case (state)
         ST_FETCH:   if (run) state_next = ST_DECODE0;
         ST_DECODE0: state_next = (len_now != 2'd0) ? ST_DECODE1 : ST_EXECUTE;
         ST_DECODE1: state_next = (len_now == 2'd2) ? ST_DECODE2 : ST_EXECUTE;
         ST_DECODE2: state_next = ST_EXECUTE;
         ST_EXECUTE: state_next = ST_FETCH;
         default:    state_next = ST_FETCH;
      endcase
   end

   //////////////////////////////////////////////////
   // program counter

   assign take = (op_q == OP_SJMP) ||
                 (op_q == OP_JZ && i_acc_zero) ||
                 (op_q == OP_JNZ && !i_acc_zero);
   assign pc_rel = pc + {{(CODE_AW-8){h_q[7]}}, h_q};   // signed offset from next pc
   assign pc_abs = {h_q[CODE_AW-9:0], l_q};

   always_comb begin
      pc_next = pc;
      case (state)
         ST_FETCH:   if (run) pc_next = pc + 1'b1;
         ST_DECODE0: if (len_now != 2'd0) pc_next = pc + 1'b1;
         ST_DECODE1: if (len_now == 2'd2) pc_next = pc + 1'b1;
         ST_EXECUTE: begin
            if (op_q == OP_LJMP)
               pc_next = pc_abs;
            else if (take)
               pc_next = pc_rel;
         end
         default: pc_next = pc;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= ST_FETCH;
         pc    <= '0;
         run   <= 1'b0;
      end else begin
         state <= state_next;
         pc    <= pc_next;
         if (i_load_done) run <= 1'b1;
      end
   end

   // operand latches, code data lands one cycle after its address
   always_ff @(posedge i_clk) begin
      if (state == ST_DECODE0) op_q <= op_now;
      if (state == ST_DECODE1) h_q <= i_code_data;
      if (state == ST_DECODE2) l_q <= i_code_data;
   end

   assign o_pc   = pc;
   assign o_exec = '{ex: (state == ST_EXECUTE), instr: '{op: op_q, h_data: h_q, l_data: l_q}};

   a_state_legal: assert property (@(posedge i_clk) disable iff (!i_nrst)
      state inside {ST_FETCH, ST_DECODE0, ST_DECODE1, ST_DECODE2, ST_EXECUTE});
   a_exec_then_fetch: assert property (@(posedge i_clk) disable iff (!i_nrst)
      state == ST_EXECUTE |=> state == ST_FETCH);

endmodule

// File: logic/ice51_pkg.sv
package ice51_pkg;

   //////////////////////////////////////////////////
   // serial timing and address map

   localparam int SAMPLE_MAX = 104;   // last count of a bit period
   localparam int CODE_AW    = 10;
   localparam int LOAD_AW    = 9;     // wraps after 512 bytes

   localparam logic [15:0] TX_DATA_ADDR = 16'h0201;   // movx store sends a
   localparam logic [15:0] TX_STAT_ADDR = 16'h0200;   // movx load reads busy

   //////////////////////////////////////////////////
   // sequencer states and opcodes

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_DECODE0,
      ST_DECODE1,
      ST_DECODE2,
      ST_EXECUTE
   } cpu_state_e;

   typedef enum logic [7:0] {
      OP_LJMP   = 8'h02,   // ljmp addr16
      OP_INCA   = 8'h04,
      OP_DECA   = 8'h14,
      OP_ADDAI  = 8'h24,   // add a,#imm
      OP_ORLAI  = 8'h44,
      OP_ANLAI  = 8'h54,
      OP_JZ     = 8'h60,
      OP_XRLAI  = 8'h64,
      OP_JNZ    = 8'h70,
      OP_MOVAI  = 8'h74,   // mov a,#imm
      OP_SJMP   = 8'h80,
      OP_MOVDP  = 8'h90,   // mov dptr,#imm16
      OP_MOVXAD = 8'hE0,   // movx a,@dptr
      OP_CLRA   = 8'hE4,
      OP_MOVXDA = 8'hF0,   // movx @dptr,a
      OP_CPLA   = 8'hF4
   } opcode_e;

   //////////////////////////////////////////////////
   // bundles between units

   typedef struct packed {
      logic               wr;
      logic [CODE_AW-1:0] addr;
      logic [7:0]         data;
   } code_wr_t;

   typedef struct packed {
      opcode_e    op;
      logic [7:0] h_data;   // first operand byte
      logic [7:0] l_data;   // second operand byte
   } instr_t;

   typedef struct packed {
      logic   ex;           // high in execute
      instr_t instr;
   } exec_t;

endpackage

// File: logic/ice51_top.sv
`timescale 1ns/1ps

module ice51_top (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  logic                          i_uart_rx,
   output logic                          o_uart_tx,
   output logic                          o_code_wr,
   output logic [ice51_pkg::CODE_AW-1:0] o_code_addr,
   output logic [7:0]                    o_code_data,
   input  logic [7:0]                    i_code_data
);
   import ice51_pkg::*;

   code_wr_t           load_wr;
   logic               load_done;
   logic [CODE_AW-1:0] pc;
   exec_t              exec;
   logic               acc_zero;
   logic               tx_start;
   logic [7:0]         tx_byte;
   logic               tx_busy;

   //////////////////////////////////////////////////
   // units

   uart_rx_loader u_loader (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx        (i_uart_rx),
      .o_load_wr   (load_wr),
      .o_load_done (load_done)
   );

   cpu_sequencer u_seq (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code_data (i_code_data),
      .i_acc_zero  (acc_zero),
      .o_pc        (pc),
      .o_exec      (exec)
   );

   cpu_datapath u_dp (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_exec     (exec),
      .i_tx_busy  (tx_busy),
      .o_acc_zero (acc_zero),
      .o_tx_start (tx_start),
      .o_tx_byte  (tx_byte)
   );

   uart_tx u_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (tx_start),
      .i_byte  (tx_byte),
      .o_tx    (o_uart_tx),
      .o_busy  (tx_busy)
   );

   //////////////////////////////////////////////////
   // code memory port

   assign o_code_wr   = load_wr.wr;
   assign o_code_data = load_wr.data;
   // last write still owns the address in the cycle load_done rises
   assign o_code_addr = (load_done && !load_wr.wr) ? pc : load_wr.addr;

endmodule

// File: logic/uart_rx_loader.sv
`timescale 1ns/1ps

module uart_rx_loader (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_rx,
   output ice51_pkg::code_wr_t o_load_wr,
   output logic                o_load_done
);
   import ice51_pkg::*;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   rx_state_e                       state;
   logic                            rx_q;
   logic [$clog2(SAMPLE_MAX+1)-1:0] cnt;
   logic [7:0]                      shift;
   logic [LOAD_AW-1:0]              load_cnt;
   logic                            done_q;
   logic                            full;
   logic                            half;
   logic                            byte_done;

   assign full      = (cnt == SAMPLE_MAX);
   assign half      = (cnt == SAMPLE_MAX / 2);
   assign byte_done = (state == RX_STOP) && full;   // middle of stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_q     <= 1'b1;   // line idles high
         state    <= RX_IDLE;
         cnt      <= '0;
         shift    <= '0;
         load_cnt <= '0;
         done_q   <= 1'b0;
      end else begin
         rx_q <= i_rx;

         // sample counter restarts at every decision point
         if (state == RX_IDLE || (state == RX_START && half) || full)
            cnt <= '0;
         else
            cnt <= cnt + 1'b1;

         case (state)
            RX_IDLE: if (!rx_q) state <= RX_START;
            RX_START: if (half) state <= rx_q ? RX_IDLE : RX_DATA;   // glitch back to idle
            RX_DATA: if (full && shift[0]) state <= RX_STOP;        // marker reached bit 0
            RX_STOP: if (full) state <= RX_IDLE;
            default: state <= RX_IDLE;
         endcase

         if (state == RX_IDLE && !rx_q)
            shift <= 8'h80;                       // start marker
         else if (state == RX_DATA && full)
            shift <= {rx_q, shift[7:1]};          // lsb first

         if (byte_done && !done_q) load_cnt <= load_cnt + 1'b1;
         if (o_load_done) done_q <= 1'b1;
      end
   end

   assign o_load_done = done_q | (byte_done && (load_cnt == '1));
   assign o_load_wr   = '{wr: byte_done && !done_q, addr: CODE_AW'(load_cnt), data: shift};

   a_no_wr_after_load: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_load_done |=> !o_load_wr.wr);

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_start,
   input  logic [7:0] i_byte,
   output logic       o_tx,
   output logic       o_busy
);
   import ice51_pkg::*;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_SEND
   } tx_state_e;

   tx_state_e                       state;
   logic [$clog2(SAMPLE_MAX+1)-1:0] cnt;
   logic [3:0]                      bits;
   logic [7:0]                      shift;
   logic                            tick;
   logic                            last;

   assign tick = (cnt == SAMPLE_MAX);
   assign last = tick && (bits == 4'd9);   // 8 data plus 2 stop periods

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= TX_IDLE;
         cnt   <= '0;
         bits  <= '0;
      end else begin
         cnt  <= (state == TX_IDLE || tick) ? '0 : cnt + 1'b1;
         bits <= (state != TX_SEND || last) ? '0 : bits + {3'd0, tick};
         case (state)
            TX_IDLE:  if (i_start) state <= TX_START;   // stores while busy are dropped
            TX_START: if (tick) state <= TX_SEND;
            TX_SEND:  if (last) state <= TX_IDLE;
            default:  state <= TX_IDLE;
         endcase
      end
   end

   // msb first, ones shifted in become the stop level
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start)
         shift <= i_byte;
      else if (state == TX_SEND && tick)
         shift <= {shift[6:0], 1'b1};
   end

   always_comb begin
      case (state)
         TX_START: o_tx = 1'b0;
         TX_SEND:  o_tx = shift[7];
         default:  o_tx = 1'b1;
      endcase
   end

   assign o_busy = (state != TX_IDLE);

   a_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      state == TX_IDLE |-> o_tx);

endmodule

// File: run_sim.sh
#!/bin/sh
# build the ice51 testbench with Verilator, run it, judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_ice51 -f ice51.f \
   && ./obj_dir/Vtb_ice51 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "ALL CHECKS PASSED" sim.log 2>/dev/null && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: verif/tb_ice51.sv
`timescale 1ns/1ps

module tb_ice51;
   import ice51_pkg::*;

   localparam int BIT_CLKS   = SAMPLE_MAX + 1;
   localparam int HALF_CLKS  = BIT_CLKS / 2;
   localparam int FRAME_CLKS = 11 * BIT_CLKS;
   localparam int QUIET_CLKS = 4 * FRAME_CLKS;   // idle window after the last byte
   localparam int N_LOAD     = 512;
   localparam int MAX_CYCLES = 600_000;          // 512 x 1050 load, program, margin

   // operands for the logic-op value
   localparam logic [7:0] MOV_IMM = 8'h3C;
   localparam logic [7:0] ORL_IMM = 8'h81;
   localparam logic [7:0] ANL_IMM = 8'hF5;
   localparam logic [7:0] XRL_IMM = 8'h5A;

   logic               i_clk;
   logic               i_nrst;
   logic               i_uart_rx;
   logic               o_uart_tx;
   logic               o_code_wr;
   logic [CODE_AW-1:0] o_code_addr;
   logic [7:0]         o_code_data;
   logic [7:0]         i_code_data = 8'h00;

   logic [7:0]         code_mem [0:(1 << CODE_AW) - 1];
   logic [CODE_AW-1:0] addr_q = '0;
   logic [7:0]         image [0:N_LOAD-1];
   logic [7:0]         exp_tx [0:2];
   logic [9:0]         sent_count = '0;
   logic [9:0]         wr_count = '0;
   logic               byte_end = 1'b0;
   logic               load_sent = 1'b0;
   logic [7:0]         rx_byte = 8'h00;
   logic               rx_valid = 1'b0;
   logic               rx_frame_ok = 1'b1;
   int                 rx_idx = 0;
   int                 rx_count = 0;
   int                 errors = 0;
   int                 cycles = 0;
   int                 wp;
   logic [7:0]         imm_x;
   logic [7:0]         imm_y;
   int unsigned        seed_draw;

   ice51_top uut (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_uart_tx   (o_uart_tx),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data),
      .i_code_data (i_code_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   // code memory, one cycle read latency
   always @(negedge i_clk) begin
      if (o_code_wr) begin
         code_mem[o_code_addr] <= o_code_data;
         wr_count <= wr_count + 10'd1;
      end
      i_code_data <= code_mem[addr_q];
      addr_q <= o_code_addr;
   end

   //////////////////////////////////////////////////
   // helpers

   task automatic note_fail(input string msg);
      errors++;
      $display("Fail at %0t ns: %s", $time, msg);
   endtask

   task automatic put_instr(input logic [7:0] op, input int len, input logic [15:0] arg);
      image[wp] = op;
      if (len == 2)
         image[wp + 1] = arg[7:0];
      if (len == 3) begin
         image[wp + 1] = arg[15:8];   // high byte first
         image[wp + 2] = arg[7:0];
      end
      wp = wp + len;
   endtask

   task automatic put_poll();
      put_instr(OP_MOVDP, 3, TX_STAT_ADDR);
      put_instr(OP_MOVXAD, 1, 16'h0000);
      put_instr(OP_JNZ, 2, 16'h00FD);   // back to the movx
   endtask

   task automatic put_send();
      put_instr(OP_MOVDP, 3, TX_DATA_ADDR);
      put_instr(OP_MOVXDA, 1, 16'h0000);
   endtask

   task automatic build_image();
      for (wp = 0; wp < N_LOAD; wp++)
         image[wp] = 8'h00;                          // nop fill
      wp = 0;
      put_instr(OP_MOVAI, 2, {8'h00, imm_x});
      put_instr(OP_ADDAI, 2, {8'h00, imm_y});
      put_send();
      put_poll();
      put_instr(OP_MOVAI, 2, {8'h00, MOV_IMM});
      put_instr(OP_ORLAI, 2, {8'h00, ORL_IMM});
      put_instr(OP_ANLAI, 2, {8'h00, ANL_IMM});
      put_instr(OP_XRLAI, 2, {8'h00, XRL_IMM});
      put_instr(OP_CPLA, 1, 16'h0000);
      put_send();
      put_poll();
      put_instr(OP_MOVAI, 2, 16'h0003);
      put_instr(OP_DECA, 1, 16'h0000);
      put_instr(OP_JNZ, 2, 16'h00FD);
      put_instr(OP_MOVAI, 2, 16'h00FD);           // second count, upward to zero
      put_instr(OP_INCA, 1, 16'h0000);
      put_instr(OP_JNZ, 2, 16'h00FD);
      put_instr(OP_CLRA, 1, 16'h0000);
      put_instr(OP_INCA, 1, 16'h0000);
      put_send();
      put_instr(OP_LJMP, 3, 16'h0100);
      wp = 'h100;
      put_instr(OP_SJMP, 2, 16'h00FE);            // parks here
   endtask

   // acc after the two loops, clr and inc
   function automatic logic [7:0] count_loop_value();
      logic [7:0] a;
      a = 8'd3;
      while (a != 8'd0)
         a = a - 8'd1;
      a = 8'hFD;
      a = a + 8'd1;
      while (a != 8'd0)
         a = a + 8'd1;
      a = 8'd0;
      a = a + 8'd1;
      return a;
   endfunction

   task send_byte(input logic [7:0] b);
      int k;
      i_uart_rx = 1'b0;
      repeat (BIT_CLKS) @(negedge i_clk);
      for (k = 0; k < 8; k++) begin
         i_uart_rx = b[k];                        // lsb first
         repeat (BIT_CLKS) @(negedge i_clk);
      end
      i_uart_rx = 1'b1;
      repeat (BIT_CLKS - 1) @(negedge i_clk);
      sent_count = sent_count + 10'd1;
      byte_end = 1'b1;
      @(negedge i_clk);
      byte_end = 1'b0;
   endtask

   task finish_run();
      $display("errors: %0d, code writes: %0d, bytes sent back: %0d",
               errors, wr_count, rx_count);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   endtask

   //////////////////////////////////////////////////
   // serial monitor, msb first

   initial begin : serial_monitor
      logic [7:0] b;
      logic       ok;
      int         k;
      forever begin
         @(negedge i_clk);
         if (i_nrst && !o_uart_tx) begin
            repeat (HALF_CLKS) @(negedge i_clk);
            ok = !o_uart_tx;                      // start bit still low
            for (k = 7; k >= 0; k--) begin
               repeat (BIT_CLKS) @(negedge i_clk);
               b[k] = o_uart_tx;
            end
            repeat (BIT_CLKS) @(negedge i_clk);
            ok = ok && o_uart_tx;
            repeat (BIT_CLKS) @(negedge i_clk);
            ok = ok && o_uart_tx;
            rx_byte = b;
            rx_idx = rx_count;
            rx_frame_ok = ok;
            rx_valid = 1'b1;
            @(negedge i_clk);
            rx_valid = 1'b0;
            rx_count = rx_count + 1;
         end
      end
   end

   //////////////////////////////////////////////////
   // checks

   a_reset_idle: assert property (@(posedge i_clk) !i_nrst |-> (o_uart_tx && !o_code_wr))
      else note_fail("serial line or code write not idle in reset");
   a_wr_match: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_code_wr |-> (o_code_addr == sent_count && o_code_data == image[sent_count[8:0]]))
      else note_fail("code write address or data differs from the byte sent");
   a_wr_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_code_wr |=> !o_code_wr)
      else note_fail("code write strobe longer than one cycle");
   a_wr_per_byte: assert property (@(posedge i_clk) disable iff (!i_nrst)
      byte_end |-> wr_count == (load_sent ? 10'(N_LOAD) : sent_count))
      else note_fail("code write count differs from bytes sent");
   a_no_wr_after_load: assert property (@(posedge i_clk) disable iff (!i_nrst)
      load_sent |-> !o_code_wr)
      else note_fail("code write after the last byte");
   a_pc_from_zero: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (o_code_wr && o_code_addr == 10'd511) |=>
         o_code_addr == 10'd0 ##1 o_code_addr == 10'd1)
      else note_fail("code address does not restart at 0 after loading");
   a_tx_extra: assert property (@(posedge i_clk) disable iff (!i_nrst)
      rx_valid |-> rx_idx < 3)
      else note_fail("more bytes transmitted than the program sends");
   a_tx_value: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (rx_valid && rx_idx < 3) |-> rx_byte == exp_tx[rx_idx])
      else note_fail("transmitted byte differs from expected value");
   a_tx_frame: assert property (@(posedge i_clk) disable iff (!i_nrst)
      rx_valid |-> rx_frame_ok)
      else note_fail("bad start or stop level in transmitted frame");
   a_line_quiet: assert property (@(posedge i_clk) disable iff (!i_nrst)
      rx_count >= 3 |-> o_uart_tx)
      else note_fail("serial line active after the last byte");

   // hang guard
   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin : main_flow
      int i;
      i_nrst = 1'b0;
      i_uart_rx = 1'b1;
      seed_draw = $urandom(33298);
      imm_x = 8'($urandom);
      imm_y = 8'($urandom);
      build_image();
      exp_tx[0] = imm_x + imm_y;                  // wraps mod 256
      exp_tx[1] = ~(((MOV_IMM | ORL_IMM) & ANL_IMM) ^ XRL_IMM);
      exp_tx[2] = count_loop_value();
      repeat (8) @(negedge i_clk);
      i_nrst = 1'b1;
      @(negedge i_clk);
      for (i = 0; i < N_LOAD; i++)
         send_byte(image[i]);
      load_sent = 1'b1;
      send_byte(8'hA5);                           // one byte past the image, must not land
      while (rx_count < 3)
         @(negedge i_clk);
      repeat (QUIET_CLKS) @(negedge i_clk);
      finish_run();
   end

endmodule
